//--- sim/ht_delete_checker.sv
/*
  result checker, results in task order against the test data
  per task write counts and final RAM and head table contents
*/

`timescale 1ns/1ps

module ht_delete_checker (
  input  logic                                       clk_i,
  input  logic                                       rst_i,
  input  ht_delete_pkg::ht_result_t                  result_i,
  input  logic                                       result_valid_i,
  input  logic                                       result_ready_i,
  input  logic                                       wr_en_i,
  input  logic                                       head_wr_en_i,
  input  logic                                       add_empty_ptr_en_i,
  input  logic [ht_delete_pkg::TABLE_ADDR_WIDTH-1:0] add_empty_ptr_i
);
  import ht_delete_pkg::*;

  int                          error_count  = 0;
  int                          result_count = 0;
  int                          wr_count     = 0;
  int                          head_count   = 0;
  int                          free_count   = 0;
  logic [TABLE_ADDR_WIDTH-1:0] free_addr;

  task automatic report_mismatch(input string what, input int n,
                                 input logic [63:0] got, input logic [63:0] exp);
    error_count++;
    $display("Fail %0t: result %0d %s is %0h, expected %0h", $time, n, what, got, exp);
  endtask

  task automatic check_result(input int n);
    int exp_wr;
    int exp_head;
    int exp_free;
    if (n >= tb_ht_delete.num_tasks)
      begin
        error_count++;
        $display("Fail %0t: result %0d arrived beyond the task list", $time, n);
        return;
      end
    if (result_i.key !== tb_ht_delete.task_key[n])
      report_mismatch("key", n, result_i.key, tb_ht_delete.task_key[n]);
    if (result_i.bucket !== tb_ht_delete.task_bucket[n])
      report_mismatch("bucket", n, result_i.bucket, tb_ht_delete.task_bucket[n]);
    if (result_i.rescode !== tb_ht_delete.exp_rescode[n])
      report_mismatch("rescode", n, result_i.rescode, tb_ht_delete.exp_rescode[n]);
    if (result_i.chain_state !== tb_ht_delete.exp_chain[n])
      report_mismatch("chain_state", n, result_i.chain_state, tb_ht_delete.exp_chain[n]);

    // a hit relinks once, clears once and frees one address
    exp_wr   = 0;
    exp_head = 0;
    exp_free = 0;
    if (tb_ht_delete.exp_rescode[n] == DELETE_SUCCESS)
      begin
        exp_free = 1;
        exp_head = (tb_ht_delete.exp_chain[n] == IN_HEAD) ? 1 : 0;
        exp_wr   = 2 - exp_head;
      end
    if (wr_count != exp_wr)
      report_mismatch("RAM write count", n, wr_count, exp_wr);
    if (head_count != exp_head)
      report_mismatch("head write count", n, head_count, exp_head);
    if (free_count != exp_free)
      report_mismatch("empty list push count", n, free_count, exp_free);
    else if ((exp_free == 1) && (free_addr !== tb_ht_delete.exp_free_addr[n]))
      report_mismatch("freed address", n, free_addr, tb_ht_delete.exp_free_addr[n]);
  endtask

  // --------------------
  // sampled mid cycle
  // --------------------
  always @(negedge clk_i)
    if (!rst_i)
      begin
        if (wr_en_i)
          wr_count++;
        if (head_wr_en_i)
          head_count++;
        if (add_empty_ptr_en_i)
          begin
            free_count++;
            free_addr = add_empty_ptr_i;
          end
        if (result_valid_i && result_ready_i)
          begin
            check_result(result_count);
            result_count++;
            wr_count   = 0;
            head_count = 0;
            free_count = 0;
          end
      end

  task automatic check_final_state();
    ht_ram_data_t                got;
    logic [TABLE_ADDR_WIDTH-1:0] addr;
    logic [BUCKET_WIDTH-1:0]     bkt;
    for (int i = 0; i < tb_ht_delete.num_fin; i++)
      begin
        addr = tb_ht_delete.fin_addr[i];
        got  = tb_ht_delete.ram_mem[addr];
        if (got !== tb_ht_delete.fin_data[i])
          begin
            error_count++;
            $display("Fail %0t: RAM entry %0h is %0h, expected %0h",
                     $time, addr, got, tb_ht_delete.fin_data[i]);
          end
      end
    for (int i = 0; i < tb_ht_delete.num_fin_heads; i++)
      begin
        bkt = tb_ht_delete.fin_bucket[i];
        if ((tb_ht_delete.head_val_mem[bkt] !== tb_ht_delete.fin_head_val[i]) ||
            (tb_ht_delete.fin_head_val[i] &&
             (tb_ht_delete.head_ptr_mem[bkt] !== tb_ht_delete.fin_head_ptr[i])))
          begin
            error_count++;
            $display("Fail %0t: head of bucket %0h is %0h valid %0b, expected %0h valid %0b",
                     $time, bkt, tb_ht_delete.head_ptr_mem[bkt], tb_ht_delete.head_val_mem[bkt],
                     tb_ht_delete.fin_head_ptr[i], tb_ht_delete.fin_head_val[i]);
          end
      end
  endtask

endmodule

//--- sim/ht_delete_testdata.txt
# E addr key value next_ptr next_ptr_val | H bucket head_ptr head_ptr_val   (preload)
# T key bucket rescode(0 ok,1 none) chain(0 none,1 head,2 mid,3 tail,4 miss) free_addr
# F addr key value next_ptr next_ptr_val | G bucket head_ptr head_ptr_val   (final state)
E 10 cafe0010 7010 11 1
E 11 cafe0011 7011 12 1
E 12 cafe0012 7012 13 1
E 13 cafe0013 7013 00 0
E 20 cafe0020 7020 21 1
E 21 cafe0021 7021 22 1
E 22 cafe0022 7022 00 0
E 30 cafe0030 7030 00 0
E 50 cafe0050 7050 51 1
E 51 cafe0051 7051 00 0
E 60 cafe0060 7060 61 1
E 61 cafe0061 7061 62 1
E 62 cafe0062 7062 00 0
H 01 10 1
H 02 20 1
H 03 30 1
H 04 00 0
H 05 50 1
H 06 60 1
T cafe0099 04 1 0 00
T cafe0011 01 0 2 11
T cafe0020 02 0 1 20
T cafe0013 01 0 3 13
T cafe0077 05 1 4 00
T cafe0030 03 0 1 30
T cafe0022 02 0 3 22
T cafe0010 01 0 1 10
T cafe0051 05 0 3 51
T cafe0012 01 0 1 12
T cafe0050 05 0 1 50
T cafe0012 01 1 0 00
T cafe0061 06 0 2 61
F 10 00000000 0000 00 0
F 11 00000000 0000 00 0
F 12 00000000 0000 00 0
F 13 00000000 0000 00 0
F 20 00000000 0000 00 0
F 21 cafe0021 7021 00 0
F 22 00000000 0000 00 0
F 30 00000000 0000 00 0
F 50 00000000 0000 00 0
F 51 00000000 0000 00 0
F 60 cafe0060 7060 62 1
F 61 00000000 0000 00 0
F 62 cafe0062 7062 00 0
G 01 00 0
G 02 21 1
G 03 00 0
G 04 00 0
G 05 00 0
G 06 60 1

//--- sim/tb_ht_delete.sv
/*
  testbench top with clock, reset, data RAM and head table models
  tasks and expected values come from the test data file
*/

`timescale 1ns/1ps

module tb_ht_delete;
  import ht_delete_pkg::*;

  localparam int RAM_LATENCY    = 2;
  localparam int MAX_TASKS      = 32;
  localparam int MAX_FINAL      = 64;
  localparam int ACCEPT_TIMEOUT = 200;
  localparam int DONE_TIMEOUT   = 4000;

  logic                        clk_i;
  logic                        rst_i;

  ht_task_t                    task_data;
  logic                        task_valid;
  logic                        task_ready;
  logic [KEY_WIDTH-1:0]        drv_key;
  logic [BUCKET_WIDTH-1:0]     drv_bucket;

  ht_ram_data_t                rd_data;
  logic [TABLE_ADDR_WIDTH-1:0] rd_addr;
  logic                        rd_en;
  logic [TABLE_ADDR_WIDTH-1:0] wr_addr;
  ht_ram_data_t                wr_data;
  logic                        wr_en;

  logic [BUCKET_WIDTH-1:0]     head_wr_bucket;
  logic [TABLE_ADDR_WIDTH-1:0] head_wr_ptr;
  logic                        head_wr_ptr_val;
  logic                        head_wr_en;
  logic [TABLE_ADDR_WIDTH-1:0] add_empty_ptr;
  logic                        add_empty_ptr_en;

  ht_result_t                  result;
  logic                        result_valid;
  logic                        result_ready;

  // --------------------
  // models and file contents
  // --------------------
  ht_ram_data_t                ram_mem [0:255];
  ht_ram_data_t                rd_pipe [0:RAM_LATENCY-1];
  logic [TABLE_ADDR_WIDTH-1:0] head_ptr_mem [0:255];
  logic                        head_val_mem [0:255];

  logic [KEY_WIDTH-1:0]        task_key [0:MAX_TASKS-1];
  logic [BUCKET_WIDTH-1:0]     task_bucket [0:MAX_TASKS-1];
  logic                        exp_rescode [0:MAX_TASKS-1];
  logic [2:0]                  exp_chain [0:MAX_TASKS-1];
  logic [TABLE_ADDR_WIDTH-1:0] exp_free_addr [0:MAX_TASKS-1];
  int                          num_tasks;

  logic [TABLE_ADDR_WIDTH-1:0] fin_addr [0:MAX_FINAL-1];
  ht_ram_data_t                fin_data [0:MAX_FINAL-1];
  int                          num_fin;
  logic [BUCKET_WIDTH-1:0]     fin_bucket [0:MAX_FINAL-1];
  logic [TABLE_ADDR_WIDTH-1:0] fin_head_ptr [0:MAX_FINAL-1];
  logic                        fin_head_val [0:MAX_FINAL-1];
  int                          num_fin_heads;

  int                          timeout_count;
  int                          setup_errors;
  int unsigned                 seed;
  int unsigned                 seed_draw;

  // head pointer follows the head table model up to the accept cycle
  assign task_data = {drv_key, drv_bucket, head_ptr_mem[drv_bucket], head_val_mem[drv_bucket]};

  always #10 clk_i = ~clk_i;

  ht_delete_top #(
    .RAM_LATENCY (RAM_LATENCY)
  ) UUT (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .task_i             (task_data),
    .task_valid_i       (task_valid),
    .task_ready_o       (task_ready),
    .rd_data_i          (rd_data),
    .rd_addr_o          (rd_addr),
    .rd_en_o            (rd_en),
    .wr_addr_o          (wr_addr),
    .wr_data_o          (wr_data),
    .wr_en_o            (wr_en),
    .head_wr_bucket_o   (head_wr_bucket),
    .head_wr_ptr_o      (head_wr_ptr),
    .head_wr_ptr_val_o  (head_wr_ptr_val),
    .head_wr_en_o       (head_wr_en),
    .add_empty_ptr_o    (add_empty_ptr),
    .add_empty_ptr_en_o (add_empty_ptr_en),
    .result_o           (result),
    .result_valid_o     (result_valid),
    .result_ready_i     (result_ready)
  );

  ht_delete_checker chk (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .result_i           (result),
    .result_valid_i     (result_valid),
    .result_ready_i     (result_ready),
    .wr_en_i            (wr_en),
    .head_wr_en_i       (head_wr_en),
    .add_empty_ptr_en_i (add_empty_ptr_en),
    .add_empty_ptr_i    (add_empty_ptr)
  );

  // --------------------
  // RAM and head table
  // --------------------
  always @(posedge clk_i)
    begin
      rd_pipe[0] <= rd_en ? ram_mem[rd_addr] : 'x;
      for (int i = 1; i < RAM_LATENCY; i++)
        rd_pipe[i] <= rd_pipe[i-1];
      if (wr_en)
        ram_mem[wr_addr] <= wr_data;
      if (head_wr_en)
        begin
          head_ptr_mem[head_wr_bucket] <= head_wr_ptr;
          head_val_mem[head_wr_bucket] <= head_wr_ptr_val;
        end
    end

  // read data changes 1 ns after the edge
  always @(posedge clk_i)
    begin
      #1;
      rd_data = rd_pipe[RAM_LATENCY-1];
    end

  // result stalls, drawn in the same process that sets the seed
  initial
    begin
      seed      = 32'h32a2cf19;
      seed_draw = $urandom(seed);
      forever
        begin
          @(posedge clk_i);
          #1;
          result_ready = ($urandom % 4) != 0;
        end
    end

  task automatic load_testdata();
    int          fd;
    int          kind;
    int          n;
    string       line;
    logic [31:0] f0;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    logic [31:0] f4;
    // unused entries carry an address dependent pattern
    for (int a = 0; a < 256; a++)
      begin
        ram_mem[a]      = {24'hf1f1f1, a[7:0], 8'hee, a[7:0], ~a[7:0], 1'b0};
        head_ptr_mem[a] = a[7:0];
        head_val_mem[a] = 1'b0;
      end
    num_tasks     = 0;
    num_fin       = 0;
    num_fin_heads = 0;
    fd = $fopen("sim/ht_delete_testdata.txt", "r");
    if (fd == 0)
      begin
        setup_errors++;
        $display("cannot open the test data file sim/ht_delete_testdata.txt");
        return;
      end
    while (!$feof(fd))
      begin
        line = "";
        n    = $fgets(line, fd);
        kind = 0;
        n    = $sscanf(line, "%c %h %h %h %h %h", kind, f0, f1, f2, f3, f4);
        case (kind)
          "E":
            ram_mem[f0[7:0]] = {f1, f2[15:0], f3[7:0], f4[0]};
          "H":
            begin
              head_ptr_mem[f0[7:0]] = f1[7:0];
              head_val_mem[f0[7:0]] = f2[0];
            end
          "T":
            if (num_tasks < MAX_TASKS)
              begin
                task_key[num_tasks]      = f0;
                task_bucket[num_tasks]   = f1[7:0];
                exp_rescode[num_tasks]   = f2[0];
                exp_chain[num_tasks]     = f3[2:0];
                exp_free_addr[num_tasks] = f4[7:0];
                num_tasks++;
              end
          "F":
            if (num_fin < MAX_FINAL)
              begin
                fin_addr[num_fin] = f0[7:0];
                fin_data[num_fin] = {f1, f2[15:0], f3[7:0], f4[0]};
                num_fin++;
              end
          "G":
            if (num_fin_heads < MAX_FINAL)
              begin
                fin_bucket[num_fin_heads]   = f0[7:0];
                fin_head_ptr[num_fin_heads] = f1[7:0];
                fin_head_val[num_fin_heads] = f2[0];
                num_fin_heads++;
              end
          default:
            ;
        endcase
      end
    $fclose(fd);
    if (num_tasks == 0)
      begin
        setup_errors++;
        $display("the test data file holds no delete tasks");
      end
  endtask

  // holds the task until the DUT takes it
  task automatic send_task(input int idx);
    int   cycles;
    logic accepted;
    drv_key    = task_key[idx];
    drv_bucket = task_bucket[idx];
    task_valid = 1'b1;
    accepted   = 1'b0;
    cycles     = 0;
    while (!accepted && (cycles < ACCEPT_TIMEOUT))
      begin
        @(negedge clk_i);
        accepted = task_ready;
        @(posedge clk_i);
        #1;
        cycles++;
      end
    task_valid = 1'b0;
    if (!accepted)
      begin
        timeout_count++;
        $display("timeout: task %0d was never accepted by the DUT", idx);
      end
  endtask

  task automatic wait_for_results();
    int cycles;
    cycles = 0;
    while ((chk.result_count < num_tasks) && (cycles < DONE_TIMEOUT))
      begin
        @(posedge clk_i);
        cycles++;
      end
    if (chk.result_count < num_tasks)
      begin
        timeout_count++;
        $display("timeout: only %0d of %0d results arrived", chk.result_count, num_tasks);
      end
  endtask

  initial
    begin
      clk_i         = 1'b0;
      rst_i         = 1'b1;
      task_valid    = 1'b0;
      drv_key       = '0;
      drv_bucket    = '0;
      rd_data       = '0;
      result_ready  = 1'b0;
      timeout_count = 0;
      setup_errors  = 0;
      load_testdata();
      repeat (4) @(posedge clk_i);
      #1;
      rst_i = 1'b0;
      for (int t = 0; t < num_tasks; t++)
        send_task(t);
      wait_for_results();
      repeat (5) @(posedge clk_i);
      chk.check_final_state();
      $display("summary: %0d mismatches, %0d timeouts, %0d setup errors",
               chk.error_count, timeout_count, setup_errors);
      if ((chk.error_count == 0) && (timeout_count == 0) && (setup_errors == 0))
        $display("Test completed successfully");
      else
        $display("Test failed");
      $finish;
    end

endmodule

//--- source/chain_hit_if.sv
/*
  finished chain walk outcome, walker to unlink stage
*/

`timescale 1ns/1ps

interface chain_hit_if;
  import ht_delete_pkg::*;

  // valid holds until unlink pulses done
  logic                        valid;
  logic                        done;
  ht_task_t                    task_info;
  ht_chain_state_t             chain_state;

  // matched entry, or last entry on a miss
  logic [TABLE_ADDR_WIDTH-1:0] hit_addr;
  ht_ram_data_t                hit_data;

  // entry before the hit
  logic [TABLE_ADDR_WIDTH-1:0] prev_addr;
  ht_ram_data_t                prev_data;

  modport src (
    output valid, task_info, chain_state, hit_addr, hit_data, prev_addr, prev_data,
    input  done
  );

  modport dst (
    input  valid, task_info, chain_state, hit_addr, hit_data, prev_addr, prev_data,
    output done
  );

endinterface

//--- source/ht_chain_unlink.sv
/*
  unlink stage, relinks the chain, clears the entry
  frees its address and presents the delete result
*/

`timescale 1ns/1ps

module ht_chain_unlink (
  input  logic                                       clk_i,
  input  logic                                       rst_i,
  input  logic                                       result_ready_i,

  chain_hit_if.dst                                   hit_i,

  output logic [ht_delete_pkg::TABLE_ADDR_WIDTH-1:0] wr_addr_o,
  output ht_delete_pkg::ht_ram_data_t                wr_data_o,
  output logic                                       wr_en_o,

  output logic [ht_delete_pkg::BUCKET_WIDTH-1:0]     head_wr_bucket_o,
  output logic [ht_delete_pkg::TABLE_ADDR_WIDTH-1:0] head_wr_ptr_o,
  output logic                                       head_wr_ptr_val_o,
  output logic                                       head_wr_en_o,

  output logic [ht_delete_pkg::TABLE_ADDR_WIDTH-1:0] add_empty_ptr_o,
  output logic                                       add_empty_ptr_en_o,

  output ht_delete_pkg::ht_result_t                  result_o,
  output logic                                       result_valid_o
);
  import ht_delete_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    RELINK,
    CLEAR,
    REPORT
  } unlink_state_t;

  unlink_state_t state;

  logic          is_match;
  logic          head_hit;
  ht_ram_data_t  relink_data;

  assign is_match = (hit_i.chain_state == IN_HEAD)   ||
                    (hit_i.chain_state == IN_MIDDLE) ||
                    (hit_i.chain_state == IN_TAIL);
  assign head_hit = (hit_i.chain_state == IN_HEAD);

  // --------------------
  // FSM
  // --------------------
  // walker holds the outcome stable until done, so nothing is copied here
  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      state <= IDLE;
    else
      case (state)
        IDLE:
          if (hit_i.valid)
            state <= is_match ? RELINK : REPORT;
        RELINK:
          state <= CLEAR;
        CLEAR:
          state <= REPORT;
        REPORT:
          if (result_ready_i)
            state <= IDLE;
        default:
          state <= IDLE;
      endcase

  // --------------------
  // predecessor rewrite
  // --------------------
  always_comb
    begin
      relink_data = hit_i.prev_data;
      if (hit_i.chain_state == IN_MIDDLE)
        begin
          // skip over the deleted entry
          relink_data.next_ptr     = hit_i.hit_data.next_ptr;
          relink_data.next_ptr_val = hit_i.hit_data.next_ptr_val;
        end
      else
        begin
          // predecessor becomes the new tail
          relink_data.next_ptr     = '0;
          relink_data.next_ptr_val = 1'b0;
        end
    end

  // RAM port shared by relink and clear
  assign wr_en_o   = ((state == RELINK) && !head_hit) || (state == CLEAR);
  assign wr_addr_o = (state == CLEAR) ? hit_i.hit_addr : hit_i.prev_addr;
  assign wr_data_o = (state == CLEAR) ? '0 : relink_data;

  // head table gets the successor of the old head
  assign head_wr_en_o      = (state == RELINK) && head_hit;
  assign head_wr_bucket_o  = hit_i.task_info.bucket;
  assign head_wr_ptr_o     = hit_i.hit_data.next_ptr;
  assign head_wr_ptr_val_o = hit_i.hit_data.next_ptr_val;

  // freed address goes back in the clear cycle
  assign add_empty_ptr_en_o = (state == CLEAR);
  assign add_empty_ptr_o    = hit_i.hit_addr;

  // --------------------
  // result
  // --------------------
  always_comb
    begin
      result_o.key         = hit_i.task_info.key;
      result_o.bucket      = hit_i.task_info.bucket;
      result_o.rescode     = is_match ? DELETE_SUCCESS : DELETE_NOT_SUCCESS_NO_ENTRY;
      result_o.chain_state = hit_i.chain_state;
    end

  assign result_valid_o = (state == REPORT);
  assign hit_i.done     = (state == REPORT) && result_ready_i;

endmodule

//--- source/ht_chain_walker.sv
/*
  chain walk stage, reads entries along next_ptr
  compares keys and classifies where the walk ended
*/

`timescale 1ns/1ps

module ht_chain_walker #(
  parameter int RAM_LATENCY = 2
) (
  input  logic                                       clk_i,
  input  logic                                       rst_i,

  input  ht_delete_pkg::ht_task_t                    pend_task_i,
  input  logic                                       pend_valid_i,
  output logic                                       walk_take_o,

  input  ht_delete_pkg::ht_ram_data_t                rd_data_i,
  output logic [ht_delete_pkg::TABLE_ADDR_WIDTH-1:0] rd_addr_o,
  output logic                                       rd_en_o,

  chain_hit_if.src                                   hit_o
);
  import ht_delete_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    READ,
    REPORT,
    WAIT_DONE
  } walk_state_t;

  walk_state_t                 state;

  logic [RAM_LATENCY-1:0]      rd_pipe;
  logic                        rd_data_val;
  logic                        key_match;
  logic                        got_tail;
  logic                        walk_end;

  ht_task_t                    task_q;
  logic                        in_head;
  logic [TABLE_ADDR_WIDTH-1:0] cur_addr;
  logic [TABLE_ADDR_WIDTH-1:0] prev_addr;
  ht_ram_data_t                prev_data;
  logic [TABLE_ADDR_WIDTH-1:0] hit_addr;
  ht_ram_data_t                hit_data;
  ht_chain_state_t             chain_state;

  // no new chain until unlink has finished the last one
  assign walk_take_o = (state == IDLE) && pend_valid_i;
  assign rd_addr_o   = cur_addr;

  // --------------------
  // read return tracking
  // --------------------
  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      rd_pipe <= '0;
    else
      begin
        rd_pipe[0] <= rd_en_o;
        for (int i = 1; i < RAM_LATENCY; i++)
          rd_pipe[i] <= rd_pipe[i-1];
      end

  assign rd_data_val = rd_pipe[RAM_LATENCY-1];
  assign key_match   = (rd_data_i.key == task_q.key);
  assign got_tail    = !rd_data_i.next_ptr_val;
  assign walk_end    = key_match || got_tail;

  // --------------------
  // FSM
  // --------------------
  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      begin
        state   <= IDLE;
        rd_en_o <= 1'b0;
      end
    else
      begin
        rd_en_o <= 1'b0;
        case (state)
          IDLE:
            if (walk_take_o)
              begin
                if (pend_task_i.head_ptr_val)
                  begin
                    state   <= READ;
                    rd_en_o <= 1'b1;
                  end
                else
                  state <= REPORT;
              end
          READ:
            if (rd_data_val)
              begin
                if (walk_end)
                  state <= REPORT;
                else
                  rd_en_o <= 1'b1;
              end
          // unlink is still idle in the first valid cycle
          REPORT:
            state <= WAIT_DONE;
          WAIT_DONE:
            if (hit_o.done)
              state <= IDLE;
          default:
            state <= IDLE;
        endcase
      end

  // --------------------
  // chain position and entries
  // --------------------
  always_ff @(posedge clk_i)
    if (walk_take_o)
      begin
        task_q      <= pend_task_i;
        cur_addr    <= pend_task_i.head_ptr;
        in_head     <= 1'b1;
        chain_state <= NO_CHAIN;
      end
    else if ((state == READ) && rd_data_val)
      begin
        if (walk_end)
          begin
            hit_addr <= cur_addr;
            hit_data <= rd_data_i;
            if (!key_match)
              chain_state <= IN_TAIL_NO_MATCH;
            else if (in_head)
              chain_state <= IN_HEAD;
            else if (got_tail)
              chain_state <= IN_TAIL;
            else
              chain_state <= IN_MIDDLE;
          end
        else
          begin
            // step along the chain
            prev_addr <= cur_addr;
            prev_data <= rd_data_i;
            cur_addr  <= rd_data_i.next_ptr;
            in_head   <= 1'b0;
          end
      end

  assign hit_o.valid       = (state == REPORT) || (state == WAIT_DONE);
  assign hit_o.task_info   = task_q;
  assign hit_o.chain_state = chain_state;
  assign hit_o.hit_addr    = hit_addr;
  assign hit_o.hit_data    = hit_data;
  assign hit_o.prev_addr   = prev_addr;
  assign hit_o.prev_data   = prev_data;

endmodule

//--- source/ht_delete_dispatch.sv
/*
  task acceptance stage, one pending task slot
*/

`timescale 1ns/1ps

module ht_delete_dispatch (
  input  logic                    clk_i,
  input  logic                    rst_i,

  input  ht_delete_pkg::ht_task_t task_i,
  input  logic                    task_valid_i,
  input  logic                    walk_take_i,

  output logic                    task_ready_o,
  output ht_delete_pkg::ht_task_t pend_task_o,
  output logic                    pend_valid_o
);

  logic accept;

  // slot is free when empty or being emptied this cycle
  assign task_ready_o = !pend_valid_o || walk_take_i;
  assign accept       = task_valid_i && task_ready_o;

  // --------------------
  // slot occupancy
  // --------------------
  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      pend_valid_o <= 1'b0;
    else
      begin
        if (accept)
          pend_valid_o <= 1'b1;
        else if (walk_take_i)
          pend_valid_o <= 1'b0;
      end

  // --------------------
  // slot contents
  // --------------------
  // overwritten only on accept, so the walker sees a stable task
  always_ff @(posedge clk_i)
    if (accept)
      pend_task_o <= task_i;

endmodule

//--- source/ht_delete_pkg.sv
/*
  widths, RAM entry, delete task and result types
  result code and chain position enums
*/

package ht_delete_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int KEY_WIDTH        = 32;
  localparam int VALUE_WIDTH      = 16;
  localparam int TABLE_ADDR_WIDTH = 8;
  localparam int BUCKET_WIDTH     = 8;

  // one data RAM entry, all zero means cleared
  typedef struct packed {
    logic [KEY_WIDTH-1:0]        key;
    logic [VALUE_WIDTH-1:0]      value;
    logic [TABLE_ADDR_WIDTH-1:0] next_ptr;
    logic                        next_ptr_val;
  } ht_ram_data_t;

  // delete request, head pointer comes from the head table
  typedef struct packed {
    logic [KEY_WIDTH-1:0]        key;
    logic [BUCKET_WIDTH-1:0]     bucket;
    logic [TABLE_ADDR_WIDTH-1:0] head_ptr;
    logic                        head_ptr_val;
  } ht_task_t;

  typedef enum logic {
    DELETE_SUCCESS              = 1'b0,
    DELETE_NOT_SUCCESS_NO_ENTRY = 1'b1
  } ht_rescode_t;

  // where in the chain the walk ended
  typedef enum logic [2:0] {
    NO_CHAIN         = 3'd0,
    IN_HEAD          = 3'd1,
    IN_MIDDLE        = 3'd2,
    IN_TAIL          = 3'd3,
    IN_TAIL_NO_MATCH = 3'd4
  } ht_chain_state_t;

  typedef struct packed {
    logic [KEY_WIDTH-1:0]    key;
    logic [BUCKET_WIDTH-1:0] bucket;
    ht_rescode_t             rescode;
    ht_chain_state_t         chain_state;
  } ht_result_t;

endpackage

//--- source/ht_delete_top.sv
/*
  hash table delete engine, dispatch, chain walk and unlink
*/

`timescale 1ns/1ps

module ht_delete_top #(
  parameter int RAM_LATENCY = 2
) (
  input  logic                                       clk_i,
  input  logic                                       rst_i,

  // delete tasks
  input  ht_delete_pkg::ht_task_t                    task_i,
  input  logic                                       task_valid_i,
  output logic                                       task_ready_o,

  // data RAM
  input  ht_delete_pkg::ht_ram_data_t                rd_data_i,
  output logic [ht_delete_pkg::TABLE_ADDR_WIDTH-1:0] rd_addr_o,
  output logic                                       rd_en_o,
  output logic [ht_delete_pkg::TABLE_ADDR_WIDTH-1:0] wr_addr_o,
  output ht_delete_pkg::ht_ram_data_t                wr_data_o,
  output logic                                       wr_en_o,

  // head table
  output logic [ht_delete_pkg::BUCKET_WIDTH-1:0]     head_wr_bucket_o,
  output logic [ht_delete_pkg::TABLE_ADDR_WIDTH-1:0] head_wr_ptr_o,
  output logic                                       head_wr_ptr_val_o,
  output logic                                       head_wr_en_o,

  // empty pointer list
  output logic [ht_delete_pkg::TABLE_ADDR_WIDTH-1:0] add_empty_ptr_o,
  output logic                                       add_empty_ptr_en_o,

  // results
  output ht_delete_pkg::ht_result_t                  result_o,
  output logic                                       result_valid_o,
  input  logic                                       result_ready_i
);
  import ht_delete_pkg::*;

  ht_task_t pend_task;
  logic     pend_valid;
  logic     walk_take;

  chain_hit_if hit_bus ();

  ht_delete_dispatch dispatch (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .task_i       (task_i),
    .task_valid_i (task_valid_i),
    .walk_take_i  (walk_take),
    .task_ready_o (task_ready_o),
    .pend_task_o  (pend_task),
    .pend_valid_o (pend_valid)
  );

  ht_chain_walker #(
    .RAM_LATENCY (RAM_LATENCY)
  ) walker (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .pend_task_i  (pend_task),
    .pend_valid_i (pend_valid),
    .walk_take_o  (walk_take),
    .rd_data_i    (rd_data_i),
    .rd_addr_o    (rd_addr_o),
    .rd_en_o      (rd_en_o),
    .hit_o        (hit_bus.src)
  );

  ht_chain_unlink unlink (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .result_ready_i     (result_ready_i),
    .hit_i              (hit_bus.dst),
    .wr_addr_o          (wr_addr_o),
    .wr_data_o          (wr_data_o),
    .wr_en_o            (wr_en_o),
    .head_wr_bucket_o   (head_wr_bucket_o),
    .head_wr_ptr_o      (head_wr_ptr_o),
    .head_wr_ptr_val_o  (head_wr_ptr_val_o),
    .head_wr_en_o       (head_wr_en_o),
    .add_empty_ptr_o    (add_empty_ptr_o),
    .add_empty_ptr_en_o (add_empty_ptr_en_o),
    .result_o           (result_o),
    .result_valid_o     (result_valid_o)
  );

endmodule

//--- tb.f
source/ht_delete_pkg.sv
source/chain_hit_if.sv
source/ht_delete_dispatch.sv
source/ht_chain_walker.sv
source/ht_chain_unlink.sv
source/ht_delete_top.sv
sim/ht_delete_checker.sv
sim/tb_ht_delete.sv
